// ==== hdl/sa_ctrl_pkg.sv ====
package sa_ctrl_pkg;

    //////////////////////////////////////////////////
    // Array geometry and field widths
    //////////////////////////////////////////////////

    localparam int N_ROWS      = 4;
    localparam int N_COLS      = 4;
    localparam int MAX_FILTER  = 3;
    localparam int SEL_W       = 2;
    localparam int NCOL_W      = 2;
    localparam int TR_W        = 2;
    localparam int ROM_ADDR_W  = 10;
    localparam int FEAT_ADDR_W = 16;
    localparam int CH_W        = 6;
    localparam int ROUND_W     = 4;

    // Phase lengths in cycles
    localparam int READY_CYCLES = 3;
    localparam int DRAIN_BASE   = 7;

    // Counter widths for the fixed-length phases
    localparam int LOAD_CNT_W  = $clog2(N_COLS);
    localparam int READY_CNT_W = $clog2(READY_CYCLES);
    localparam int DRAIN_CNT_W = $clog2(DRAIN_BASE + 2 * (MAX_FILTER - 1));

    //////////////////////////////////////////////////
    // Packed types
    //////////////////////////////////////////////////

    // Per-row control word, 7 bits
    typedef struct packed {
        logic [SEL_W-1:0]  f_sel;
        logic [NCOL_W-1:0] num_cols;
        logic [TR_W-1:0]   sel_tr;
        logic              en_adder;
    } row_cfg_t;

    // One signal ROM word, row 0 in the low bits
    typedef row_cfg_t [N_ROWS-1:0] rom_word_t;

    typedef struct packed {
        logic [NCOL_W-1:0]      filter_size;
        logic [CH_W-1:0]        total_channels;
        logic [ROUND_W-1:0]     filter_rounds;
        logic [ROUND_W-1:0]     input_rounds;
        logic [FEAT_ADDR_W-1:0] inputs_per_round;
    } layer_cfg_t;

    // Strobes decoded from the current phase
    typedef struct packed {
        logic rst;
        logic load;
        logic ready;
        logic start_op;
        logic rd_feature;
    } seq_ctrl_t;

    typedef enum logic [3:0] {
        IDLE          = 4'd0,
        LOAD          = 4'd1,
        WAIT_WEIGHT   = 4'd2,
        READY         = 4'd3,
        START         = 4'd4,
        DRAIN         = 4'd5,
        STORE         = 4'd6,
        NEXT_CHANNELS = 4'd7,
        NEXT_FILTERS  = 4'd8,
        NEXT_INPUT    = 4'd9,
        WAIT_BRAM     = 4'd10
    } phase_t;

endpackage

// ==== hdl/sa_rom_decode.sv ====
`timescale 1ns/1ps

module sa_rom_decode (
    input  logic                                                   clk_i,
    input  logic                                                   sel_mux_tr_rst,
    input  sa_ctrl_pkg::seq_ctrl_t                                 ctrl_i,
    input  sa_ctrl_pkg::rom_word_t                                 rom_data_i,
    output logic [sa_ctrl_pkg::ROM_ADDR_W-1:0]                     rom_addr_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] num_cols_o,
    output sa_ctrl_pkg::row_cfg_t [sa_ctrl_pkg::N_ROWS-1:0]         row_cfg_o
);
    import sa_ctrl_pkg::*;

    // Registered fields handed to the array
    rom_word_t                   cfg_q;
    // First stage of the transpose select
    logic [N_ROWS-1:0][TR_W-1:0] tr_pre_q;

    //////////////////////////////////////////////////
    // ROM address
    //////////////////////////////////////////////////

    // Only cleared while idle, so it keeps counting across passes
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            rom_addr_o <= '0;
        end else if (ctrl_i.rst) begin
            rom_addr_o <= '0;
        end else if (ctrl_i.load) begin
            rom_addr_o <= rom_addr_o + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Field registers
    //////////////////////////////////////////////////

    // Column counts of the word on the bus right now
    always_comb begin
        for (int r = 0; r < N_ROWS; r++) begin
            num_cols_o[r] = rom_data_i[r].num_cols;
        end
    end

    // sel_tr lags one load behind the other fields
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            cfg_q    <= '0;
            tr_pre_q <= '0;
        end else if (ctrl_i.rst) begin
            cfg_q    <= '0;
            tr_pre_q <= '0;
        end else if (ctrl_i.load) begin
            for (int r = 0; r < N_ROWS; r++) begin
                cfg_q[r].f_sel    <= rom_data_i[r].f_sel;
                cfg_q[r].num_cols <= rom_data_i[r].num_cols;
                cfg_q[r].en_adder <= rom_data_i[r].en_adder;
                cfg_q[r].sel_tr   <= tr_pre_q[r];
                tr_pre_q[r]       <= rom_data_i[r].sel_tr;
            end
        end
    end

    assign row_cfg_o = cfg_q;

endmodule

// ==== hdl/sa_phase_seq.sv ====
`timescale 1ns/1ps

module sa_phase_seq (
    input  logic                                  clk_i,
    input  logic                                  sel_mux_tr_rst,
    input  sa_ctrl_pkg::layer_cfg_t               layer_cfg_i,
    input  logic                                  input_ready_i,
    input  logic                                  weight_ready_i,
    input  logic                                  bram_ready_i,
    output sa_ctrl_pkg::seq_ctrl_t                ctrl_o,
    output logic [sa_ctrl_pkg::NCOL_W-1:0]        filter_size_o,
    output logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0]   feat_addr_o,
    output logic                                  layer_done_o
);
    import sa_ctrl_pkg::*;

    phase_t                  state_q;
    phase_t                  state_d;
    phase_t                  resume_ph;
    layer_cfg_t              cfg_q;

    logic [LOAD_CNT_W-1:0]   load_cnt_q;
    logic [READY_CNT_W-1:0]  ready_cnt_q;
    logic [FEAT_ADDR_W-1:0]  start_cnt_q;
    logic [DRAIN_CNT_W-1:0]  drain_cnt_q;
    logic [DRAIN_CNT_W-1:0]  drain_last;

    // One spare bit so the accumulator cannot wrap past total_channels
    logic [CH_W:0]           ch_cnt_q;
    logic [CH_W:0]           ch_step;
    logic [ROUND_W-1:0]      filt_rnd_q;
    logic [ROUND_W-1:0]      in_rnd_q;
    logic [ROUND_W-1:0]      filt_rnd_nxt;
    logic [ROUND_W-1:0]      in_rnd_nxt;

    logic load_last;
    logic ready_last;
    logic start_last;
    logic drain_done;
    logic ch_full;
    logic filt_wrap;
    logic layer_end;

    //////////////////////////////////////////////////
    // Phase end conditions
    //////////////////////////////////////////////////

    assign load_last  = (load_cnt_q == LOAD_CNT_W'(N_COLS - 1));
    assign ready_last = (ready_cnt_q == READY_CNT_W'(READY_CYCLES - 1));
    assign start_last = (start_cnt_q == cfg_q.inputs_per_round - FEAT_ADDR_W'(1));

    // Pipeline depth grows by two cycles per extra filter row
    assign drain_last = DRAIN_CNT_W'(DRAIN_BASE - 1 + 2 * (int'(cfg_q.filter_size) - 1));
    assign drain_done = (drain_cnt_q == drain_last);

    assign ch_full      = (ch_cnt_q >= {1'b0, cfg_q.total_channels});
    assign filt_rnd_nxt = filt_rnd_q + 1'b1;
    assign in_rnd_nxt   = in_rnd_q + 1'b1;
    assign filt_wrap    = (filt_rnd_nxt == cfg_q.filter_rounds);
    assign layer_end    = filt_wrap && (in_rnd_nxt == cfg_q.input_rounds);

    // Channels covered per pass, N_ROWS / filter_size
    always_comb begin
        case (cfg_q.filter_size)
            2'd2:    ch_step = (CH_W + 1)'(N_ROWS / 2);
            2'd3:    ch_step = (CH_W + 1)'(N_ROWS / 3);
            default: ch_step = (CH_W + 1)'(N_ROWS);
        endcase
    end

    //////////////////////////////////////////////////
    // Phase FSM
    //////////////////////////////////////////////////

    // Shared exit rule of idle and the three next phases
    always_comb begin
        if (input_ready_i && weight_ready_i) begin
            resume_ph = LOAD;
        end else if (input_ready_i) begin
            resume_ph = WAIT_WEIGHT;
        end else begin
            resume_ph = state_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, NEXT_CHANNELS, NEXT_FILTERS, NEXT_INPUT: state_d = resume_ph;
            WAIT_WEIGHT: if (weight_ready_i) state_d = LOAD;
            LOAD:        if (load_last) state_d = WAIT_BRAM;
            WAIT_BRAM:   if (bram_ready_i) state_d = READY;
            READY:       if (ready_last) state_d = START;
            START:       if (start_last) state_d = DRAIN;
            DRAIN: begin
                if (drain_done) begin
                    state_d = ch_full ? STORE : NEXT_CHANNELS;
                end
            end
            STORE: begin
                if (layer_end) begin
                    state_d = IDLE;
                end else if (filt_wrap) begin
                    state_d = NEXT_INPUT;
                end else begin
                    state_d = NEXT_FILTERS;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        ctrl_o = '0;
        case (state_q)
            IDLE:  ctrl_o.rst = 1'b1;
            LOAD:  ctrl_o.load = 1'b1;
            READY: begin
                ctrl_o.ready      = 1'b1;
                ctrl_o.rd_feature = 1'b1;
            end
            START: begin
                ctrl_o.start_op   = 1'b1;
                ctrl_o.rd_feature = 1'b1;
            end
            DRAIN: ctrl_o.start_op = 1'b1;
            default: ctrl_o = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Counters and layer registers
    //////////////////////////////////////////////////

    // Layer parameters follow the inputs only while idle
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            cfg_q <= '0;
        end else if (state_q == IDLE) begin
            cfg_q <= layer_cfg_i;
        end
    end

    // Each phase counter restarts outside its own phase
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            load_cnt_q  <= '0;
            ready_cnt_q <= '0;
            start_cnt_q <= '0;
            drain_cnt_q <= '0;
        end else begin
            load_cnt_q  <= (state_q == LOAD)  ? load_cnt_q + 1'b1  : '0;
            ready_cnt_q <= (state_q == READY) ? ready_cnt_q + 1'b1 : '0;
            start_cnt_q <= (state_q == START) ? start_cnt_q + 1'b1 : '0;
            drain_cnt_q <= (state_q == DRAIN) ? drain_cnt_q + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            ch_cnt_q   <= '0;
            filt_rnd_q <= '0;
            in_rnd_q   <= '0;
        end else if (state_q == IDLE) begin
            ch_cnt_q   <= '0;
            filt_rnd_q <= '0;
            in_rnd_q   <= '0;
        end else if (state_q == START && start_last) begin
            ch_cnt_q <= ch_cnt_q + ch_step;
        end else if (state_q == STORE) begin
            ch_cnt_q <= '0;
            if (filt_wrap) begin
                filt_rnd_q <= '0;
                in_rnd_q   <= layer_end ? '0 : in_rnd_nxt;
            end else begin
                filt_rnd_q <= filt_rnd_nxt;
            end
        end
    end

    // Feature address, rewound on drain entry
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            feat_addr_o <= '0;
        end else if (state_q == START && start_last) begin
            feat_addr_o <= '0;
        end else if (ctrl_o.rd_feature) begin
            feat_addr_o <= feat_addr_o + 1'b1;
        end
    end

    assign layer_done_o  = (state_q == STORE) && layer_end;
    assign filter_size_o = cfg_q.filter_size;

endmodule

// ==== hdl/sa_array_map.sv ====
`timescale 1ns/1ps

module sa_array_map (
    input  logic                                                   clk_i,
    input  logic                                                   sel_mux_tr_rst,
    input  sa_ctrl_pkg::seq_ctrl_t                                 ctrl_i,
    input  logic [sa_ctrl_pkg::NCOL_W-1:0]                         filter_size_i,
    input  logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] num_cols_i,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] row_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] column_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                         sel_mux_node_o
);
    import sa_ctrl_pkg::*;

    logic [N_ROWS-1:0][NCOL_W-1:0] col_cnt_q;

    // Rows are numbered 1..filter_size, repeating down the array
    always_comb begin
        logic [NCOL_W-1:0] idx;
        idx = '0;
        for (int r = 0; r < N_ROWS; r++) begin
            if (idx == filter_size_i) begin
                idx = '0;
            end
            row_num_o[r]      = idx + NCOL_W'(1);
            // Last row of a filter group feeds the node adder directly
            sel_mux_node_o[r] = (row_num_o[r] != filter_size_i);
            idx               = idx + NCOL_W'(1);
        end
    end

    //////////////////////////////////////////////////
    // Column counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            col_cnt_q    <= '0;
            column_num_o <= '0;
        end else if (ctrl_i.rst) begin
            col_cnt_q <= '0;
        end else if (ctrl_i.load) begin
            for (int r = 0; r < N_ROWS; r++) begin
                column_num_o[r] <= num_cols_i[r] - col_cnt_q[r];
                if (col_cnt_q[r] == num_cols_i[r] - NCOL_W'(1)) begin
                    col_cnt_q[r] <= '0;
                end else begin
                    col_cnt_q[r] <= col_cnt_q[r] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/sa_ctrl_top.sv ====
`timescale 1ns/1ps

module sa_ctrl_top (
    input  logic                                                   clk_i,
    input  logic                                                   sel_mux_tr_rst,
    input  sa_ctrl_pkg::layer_cfg_t                                layer_cfg_i,
    input  logic                                                   input_ready_i,
    input  logic                                                   weight_ready_i,
    input  logic                                                   bram_ready_i,
    input  sa_ctrl_pkg::rom_word_t                                 rom_data_i,
    output logic [sa_ctrl_pkg::ROM_ADDR_W-1:0]                     rom_addr_o,
    output logic [sa_ctrl_pkg::FEAT_ADDR_W-1:0]                    feat_addr_o,
    output logic                                                   rst_o,
    output logic                                                   load_o,
    output logic                                                   ready_o,
    output logic                                                   start_op_o,
    output logic                                                   rd_feature_o,
    output logic                                                   layer_done_o,
    output sa_ctrl_pkg::row_cfg_t [sa_ctrl_pkg::N_ROWS-1:0]         row_cfg_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] row_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0][sa_ctrl_pkg::NCOL_W-1:0] column_num_o,
    output logic [sa_ctrl_pkg::N_ROWS-1:0]                         sel_mux_node_o
);
    import sa_ctrl_pkg::*;

    seq_ctrl_t                     ctrl;
    logic [NCOL_W-1:0]             filter_size;
    logic [N_ROWS-1:0][NCOL_W-1:0] num_cols;

    sa_phase_seq u_phase_seq (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .layer_cfg_i    (layer_cfg_i),
        .input_ready_i  (input_ready_i),
        .weight_ready_i (weight_ready_i),
        .bram_ready_i   (bram_ready_i),
        .ctrl_o         (ctrl),
        .filter_size_o  (filter_size),
        .feat_addr_o    (feat_addr_o),
        .layer_done_o   (layer_done_o)
    );

    sa_rom_decode u_rom_decode (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .ctrl_i         (ctrl),
        .rom_data_i     (rom_data_i),
        .rom_addr_o     (rom_addr_o),
        .num_cols_o     (num_cols),
        .row_cfg_o      (row_cfg_o)
    );

    sa_array_map u_array_map (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .ctrl_i         (ctrl),
        .filter_size_i  (filter_size),
        .num_cols_i     (num_cols),
        .row_num_o      (row_num_o),
        .column_num_o   (column_num_o),
        .sel_mux_node_o (sel_mux_node_o)
    );

    // Phase strobes out to the array and memories
    assign rst_o        = ctrl.rst;
    assign load_o       = ctrl.load;
    assign ready_o      = ctrl.ready;
    assign start_op_o   = ctrl.start_op;
    assign rd_feature_o = ctrl.rd_feature;

endmodule

// ==== dv/sa_ctrl_tb.sv ====
`timescale 1ns/1ps

module sa_ctrl_tb;
    import sa_ctrl_pkg::*;

    localparam int          N_LAYERS = 5;
    localparam logic [31:0] SEED     = 32'h7383;

    logic                          clk_i = 1'b0;
    logic                          sel_mux_tr_rst;
    layer_cfg_t                    layer_cfg_i;
    logic                          input_ready_i;
    logic                          weight_ready_i;
    logic                          bram_ready_i;
    rom_word_t                     rom_data_i;
    logic [ROM_ADDR_W-1:0]         rom_addr_o;
    logic [FEAT_ADDR_W-1:0]        feat_addr_o;
    logic                          rst_o;
    logic                          load_o;
    logic                          ready_o;
    logic                          start_op_o;
    logic                          rd_feature_o;
    logic                          layer_done_o;
    row_cfg_t [N_ROWS-1:0]         row_cfg_o;
    logic [N_ROWS-1:0][NCOL_W-1:0] row_num_o;
    logic [N_ROWS-1:0][NCOL_W-1:0] column_num_o;
    logic [N_ROWS-1:0]             sel_mux_node_o;

    // Stimulus state
    layer_cfg_t  cur_cfg = '0;
    int          layer_cnt = 0;
    logic        idle_expect = 1'b0;
    logic [31:0] rng = SEED;
    string       test_name = "reset";
    int          cycle_limit = 0;
    int          cycles = 0;

    // Reference model state
    int                            seen_layer = 0;
    int                            err_cnt = 0;
    int                            chk_cnt = 0;
    int                            done_cnt = 0;
    int                            load_run = 0;
    int                            load_phases = 0;
    int                            streams = 0;
    int                            pass_rd = 0;
    int                            drain_run = 0;
    logic                          prev_load = 1'b0;
    logic [ROM_ADDR_W-1:0]         exp_addr = '0;
    rom_word_t                     exp_cfg = '0;
    rom_word_t                     cur_word;
    logic [N_ROWS-1:0][TR_W-1:0]   exp_tr_pre = '0;
    logic [N_ROWS-1:0][NCOL_W-1:0] exp_col = '0;
    logic [N_ROWS-1:0][NCOL_W-1:0] exp_colnum = '0;

    sa_ctrl_top dut0 (.*);

    always #4 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Reference functions
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Signal ROM contents, num_cols never zero
    function automatic rom_word_t rom_word(input logic [ROM_ADDR_W-1:0] addr);
        logic [31:0] s;
        rom_word_t   w;
        s = lcg_next(lcg_next(SEED + 32'(addr)));
        w = s[31:4];
        for (int r = 0; r < N_ROWS; r++) begin
            if (w[r].num_cols == '0) begin
                w[r].num_cols = NCOL_W'(1);
            end
        end
        return w;
    endfunction

    // Combinational signal ROM
    assign rom_data_i = rom_word(rom_addr_o);

    function automatic layer_cfg_t make_cfg(input int fs, input int ch, input int fr,
                                            input int ir, input int ipr);
        layer_cfg_t c;
        c.filter_size      = NCOL_W'(fs);
        c.total_channels   = CH_W'(ch);
        c.filter_rounds    = ROUND_W'(fr);
        c.input_rounds     = ROUND_W'(ir);
        c.inputs_per_round = FEAT_ADDR_W'(ipr);
        return c;
    endfunction

    function automatic layer_cfg_t layer_at(input int idx);
        case (idx)
            0:       return make_cfg(1, 4, 1, 1, 5);
            1:       return make_cfg(2, 5, 2, 1, 3);
            2:       return make_cfg(3, 3, 1, 2, 4);
            3:       return make_cfg(1, 9, 2, 2, 2);
            default: return make_cfg(3, 2, 3, 1, 1);
        endcase
    endfunction

    // Passes per layer: rounds times channel groups, rounded up
    function automatic int exp_passes(input layer_cfg_t c);
        int step;
        step = N_ROWS / int'(c.filter_size);
        return int'(c.filter_rounds) * int'(c.input_rounds)
               * ((int'(c.total_channels) + step - 1) / step);
    endfunction

    function automatic int layer_cycles(input layer_cfg_t c);
        return exp_passes(c) * (N_COLS + READY_CYCLES + int'(c.inputs_per_round)
               + DRAIN_BASE + 2 * (int'(c.filter_size) - 1) + 4);
    endfunction

    function automatic logic [NCOL_W-1:0] row_num_ref(input int r, input int fs);
        return NCOL_W'((r % fs) + 1);
    endfunction

    function automatic logic [NCOL_W-1:0] col_out_ref(input logic [NCOL_W-1:0] nc,
                                                      input logic [NCOL_W-1:0] cnt);
        return nc - cnt;
    endfunction

    function automatic logic [NCOL_W-1:0] col_next_ref(input logic [NCOL_W-1:0] nc,
                                                       input logic [NCOL_W-1:0] cnt);
        return (cnt == nc - NCOL_W'(1)) ? '0 : cnt + NCOL_W'(1);
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_cfg(input string what, input row_cfg_t exp, input row_cfg_t act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAIL %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input logic [FEAT_ADDR_W-1:0] exp,
                              input logic [FEAT_ADDR_W-1:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAIL %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_field(input string what, input logic [NCOL_W-1:0] exp,
                               input logic [NCOL_W-1:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAIL %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAIL %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        chk_cnt++;
        if (exp != act) begin
            err_cnt++;
            $display("FAIL %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // Comparing process
    //////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!sel_mux_tr_rst) begin
            // New layer, the DUT has just been idle
            if (layer_cnt != seen_layer) begin
                seen_layer  = layer_cnt;
                exp_addr    = '0;
                exp_cfg     = '0;
                exp_tr_pre  = '0;
                exp_col     = '0;
                load_phases = 0;
                streams     = 0;
                pass_rd     = 0;
            end
            if (idle_expect) begin
                check_bit("rst_o", 1'b1, rst_o);
                check_bit("load_o", 1'b0, load_o);
                check_bit("ready_o", 1'b0, ready_o);
                check_bit("start_op_o", 1'b0, start_op_o);
                check_bit("rd_feature_o", 1'b0, rd_feature_o);
                check_bit("layer_done_o", 1'b0, layer_done_o);
            end
            for (int r = 0; r < N_ROWS; r++) begin
                check_field("column_num", exp_colnum[r], column_num_o[r]);
                if (load_o || prev_load) begin
                    check_cfg("row_cfg", exp_cfg[r], row_cfg_o[r]);
                end
            end
            if (load_o) begin
                check_addr("rom_addr", FEAT_ADDR_W'(exp_addr), FEAT_ADDR_W'(rom_addr_o));
                cur_word = rom_word(exp_addr);
                for (int r = 0; r < N_ROWS; r++) begin
                    check_field("row_num", row_num_ref(r, int'(cur_cfg.filter_size)),
                                row_num_o[r]);
                    check_bit("sel_mux_node",
                              row_num_ref(r, int'(cur_cfg.filter_size)) != cur_cfg.filter_size,
                              sel_mux_node_o[r]);
                    exp_cfg[r].f_sel    = cur_word[r].f_sel;
                    exp_cfg[r].num_cols = cur_word[r].num_cols;
                    exp_cfg[r].en_adder = cur_word[r].en_adder;
                    // Transpose select lags one load
                    exp_cfg[r].sel_tr   = exp_tr_pre[r];
                    exp_tr_pre[r]       = cur_word[r].sel_tr;
                    exp_colnum[r]       = col_out_ref(cur_word[r].num_cols, exp_col[r]);
                    exp_col[r]          = col_next_ref(cur_word[r].num_cols, exp_col[r]);
                end
                exp_addr++;
                load_run++;
            end else if (prev_load) begin
                check_count("load length", N_COLS, load_run);
                load_run = 0;
                load_phases++;
            end
            if (rd_feature_o) begin
                check_addr("feat_addr", FEAT_ADDR_W'(pass_rd), feat_addr_o);
                // Ready cycles come first, then the start cycles
                check_bit("ready_o", pass_rd < READY_CYCLES, ready_o);
                check_bit("start_op_o", pass_rd >= READY_CYCLES, start_op_o);
                pass_rd++;
                if (pass_rd == READY_CYCLES + int'(cur_cfg.inputs_per_round)) begin
                    pass_rd = 0;
                    streams++;
                end
            end
            // Drain keeps start_op_o high after the stream ends
            if (start_op_o && !rd_feature_o) begin
                drain_run++;
            end else if (drain_run != 0) begin
                check_count("drain length",
                            DRAIN_BASE + 2 * (int'(cur_cfg.filter_size) - 1), drain_run);
                drain_run = 0;
            end
            if (layer_done_o) begin
                done_cnt++;
                check_count("done pulses", layer_cnt, done_cnt);
                check_count("load phases", exp_passes(cur_cfg), load_phases);
                check_count("feature streams", exp_passes(cur_cfg), streams);
                check_count("open stream", 0, pass_rd);
            end
            prev_load = load_o;
        end
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles in %s, layer done never seen", cycles, test_name);
            $display("Checks: %0d, errors: %0d, layers done: %0d", chk_cnt, err_cnt, done_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic drive_ready(input logic wrand, input logic brand);
        rng = lcg_next(rng);
        weight_ready_i = wrand ? (rng[27:26] != 2'b00) : 1'b1;
        bram_ready_i   = brand ? (rng[30:29] == 2'b00) : 1'b1;
    endtask

    task automatic run_layer(input int idx);
        logic wrand;
        logic brand;
        wrand = (idx == 1 || idx == 3);
        brand = (idx == 2 || idx == 3);
        @(negedge clk_i);
        cur_cfg       = layer_at(idx);
        layer_cfg_i   = cur_cfg;
        test_name     = $sformatf("layer %0d", idx);
        idle_expect   = 1'b0;
        layer_cnt     = layer_cnt + 1;
        input_ready_i = 1'b1;
        drive_ready(wrand, brand);
        @(negedge clk_i);
        while (!layer_done_o) begin
            drive_ready(wrand, brand);
            @(negedge clk_i);
        end
        input_ready_i  = 1'b0;
        weight_ready_i = 1'b0;
        bram_ready_i   = 1'b0;
        @(negedge clk_i);
        idle_expect = 1'b1;
        repeat (3) @(negedge clk_i);
    endtask

    initial begin
        int total;
        total = 0;
        for (int i = 0; i < N_LAYERS; i++) begin
            total += layer_cycles(layer_at(i));
        end
        // Room for random back-pressure on top of the nominal length
        cycle_limit = 6 * total + 60 * N_LAYERS + 100;

        sel_mux_tr_rst = 1'b1;
        layer_cfg_i    = '0;
        input_ready_i  = 1'b0;
        weight_ready_i = 1'b0;
        bram_ready_i   = 1'b0;
        repeat (4) @(negedge clk_i);
        sel_mux_tr_rst = 1'b0;
        idle_expect    = 1'b1;
        test_name      = "idle";

        // Weight and buffer ready alone must not start a pass
        weight_ready_i = 1'b1;
        bram_ready_i   = 1'b1;
        repeat (6) @(negedge clk_i);
        weight_ready_i = 1'b0;
        bram_ready_i   = 1'b0;

        for (int i = 0; i < N_LAYERS; i++) begin
            run_layer(i);
        end

        $display("Checks: %0d, errors: %0d, layers done: %0d", chk_cnt, err_cnt, done_cnt);
        if (err_cnt == 0 && done_cnt == N_LAYERS) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/sa_ctrl_pkg.sv
hdl/sa_rom_decode.sv
hdl/sa_phase_seq.sv
hdl/sa_array_map.sv
hdl/sa_ctrl_top.sv
dv/sa_ctrl_tb.sv

// ==== Makefile ====
# Verilator flow for the systolic array controller

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= sa_ctrl_tb
RTL_TOP    ?= sa_ctrl_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= PASS: all tests

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qFx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
